// File: compile.f
+incdir+testbench
verilog/pdp8_pkg.sv
verilog/front_panel.sv
verilog/major_state.sv
verilog/mem_addr.sv
verilog/core_mem.sv
verilog/pdp8_console_top.sv
testbench/tb_pdp8_console.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the console testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_pdp8_console \
    -f compile.f \
    --Mdir obj_dir -o sim_pdp8

./obj_dir/sim_pdp8 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
else
    exit 1
fi

// File: testbench/tb_pdp8_model.svh
// reference model of console memory and registers, included into the testbench module
`ifndef TB_PDP8_MODEL_SVH
`define TB_PDP8_MODEL_SVH

pdp8_pkg::word_t model_mem [4096];
bit              model_valid [4096];
pdp8_pkg::word_t model_pc;
pdp8_pkg::word_t model_ma;
pdp8_pkg::word_t model_mb;

function automatic void model_reset();
    model_pc = '0;
    model_ma = '0;
    model_mb = '0;
endfunction

// load address puts the switches in both pc and ma
function automatic void model_load(input pdp8_pkg::word_t a);
    model_pc = a;
    model_ma = a;
endfunction

function automatic void model_deposit(input pdp8_pkg::word_t w);
    model_mem[model_pc]   = w;
    model_valid[model_pc] = 1'b1;
    model_mb              = w;
    model_pc              = model_pc + 12'd1;
endfunction

function automatic void model_examine();
    model_ma = model_pc;
    model_mb = model_mem[model_pc];
    model_pc = model_pc + 12'd1;
endfunction

function automatic void model_clear();
    model_mb = '0;
endfunction

// one instruction, returns 1 on HLT
function automatic bit model_step();
    pdp8_pkg::word_t here;
    pdp8_pkg::word_t inst;
    here     = model_pc;
    inst     = model_mem[here];
    model_ma = here;
    model_mb = inst;
    model_pc = here + 12'd1;
    // JMP, page bit clear selects page zero
    if (inst[11:9] == 3'o5) begin
        model_pc = (inst & 12'o0177) | (inst[7] ? (here & 12'o7600) : 12'o0000);
    end
    return inst == 12'o7402;
endfunction

`endif

// File: testbench/tb_pdp8_console.sv
// testbench for the console top level, random panel operations checked against a model
`timescale 1ns/1ns
`default_nettype none

module tb_pdp8_console;

    logic                 clk100 = 1'b0;
    logic                 arst_n;
    pdp8_pkg::word_t      sr;
    pdp8_pkg::panel_cmd_t sw;
    logic                 halt_sw;
    logic                 single_step_sw;
    pdp8_pkg::word_t      addr;
    pdp8_pkg::word_t      data;
    logic                 run;
    pdp8_pkg::state_e     state;

    integer          seed = 32'hfaf6;
    int              value_errors = 0;
    int              timeout_errors = 0;
    pdp8_pkg::word_t prog_base;
    pdp8_pkg::word_t prog_hlt;

    `include "tb_pdp8_model.svh"

    pdp8_console_top #(
        .DEBOUNCE_CYCLES(4),
        .ADDR_BITS      (12)
    ) pdp8_console_top_inst (
        .clk100        (clk100),
        .arst_n        (arst_n),
        .sr            (sr),
        .clear_sw      (sw.clear),
        .addr_load_sw  (sw.addr_load),
        .dep_sw        (sw.dep),
        .exam_sw       (sw.exam),
        .cont_sw       (sw.cont),
        .halt_sw       (halt_sw),
        .single_step_sw(single_step_sw),
        .addr          (addr),
        .data          (data),
        .run           (run),
        .state         (state)
    );

    always #5 clk100 = ~clk100;

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic pdp8_pkg::word_t rand_word();
        return pdp8_pkg::word_t'($random(seed));
    endfunction

    task automatic check_word(input string name, input pdp8_pkg::word_t got,
                              input pdp8_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s = %04o, expected %04o", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_state(input pdp8_pkg::state_e got, input pdp8_pkg::state_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns state = %s, expected %s", $time, got.name(), exp.name());
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s = %b, expected %b", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic wait_halted();
        int n;
        n = 0;
        @(negedge clk100);
        while (state != pdp8_pkg::halted && n < 500) begin
            @(negedge clk100);
            n++;
        end
        if (state != pdp8_pkg::halted) begin
            $display("timeout: sequencer did not return to halted within 500 cycles");
            timeout_errors++;
        end
    endtask

    // 12 cycles pressed, 12 released, then back to halted
    task automatic press(input pdp8_pkg::panel_cmd_t which);
        @(posedge clk100);
        sw <= which;
        repeat (12) @(posedge clk100);
        sw <= '0;
        repeat (12) @(posedge clk100);
        wait_halted();
    endtask

    task automatic load_address(input pdp8_pkg::word_t a);
        pdp8_pkg::panel_cmd_t m;
        m           = '0;
        m.addr_load = 1'b1;
        @(posedge clk100);
        sr <= a;
        press(m);
        model_load(a);
        check_word("addr", addr, model_ma);
    endtask

    task automatic deposit_word(input pdp8_pkg::word_t w);
        pdp8_pkg::panel_cmd_t m;
        m     = '0;
        m.dep = 1'b1;
        @(posedge clk100);
        sr <= w;
        press(m);
        model_deposit(w);
        check_word("data", data, model_mb);
    endtask

    task automatic examine_word();
        pdp8_pkg::panel_cmd_t m;
        m      = '0;
        m.exam = 1'b1;
        press(m);
        model_examine();
        check_word("addr", addr, model_ma);
        // never deposited means undefined contents
        if (model_valid[model_ma]) begin
            check_word("data", data, model_mb);
        end
    endtask

    task automatic clear_panel();
        pdp8_pkg::panel_cmd_t m;
        m       = '0;
        m.clear = 1'b1;
        press(m);
        model_clear();
        check_word("data", data, model_mb);
    endtask

    task automatic continue_run(input bit one_step);
        pdp8_pkg::panel_cmd_t m;
        bit                   done;
        int                   n;
        m      = '0;
        m.cont = 1'b1;
        done   = 1'b0;
        n      = 0;
        press(m);
        if (one_step) begin
            void'(model_step());
        end else begin
            while (!done && n < 64) begin
                done = model_step();
                n++;
            end
            if (!done) begin
                $display("model program ran 64 instructions without reaching HLT");
                timeout_errors++;
            end
        end
        check_bit("run", run, 1'b0);
        check_word("addr", addr, model_ma);
        check_word("data", data, model_mb);
    endtask

    // forward JMPs only, so every program reaches its HLT
    task automatic build_program();
        pdp8_pkg::word_t a;
        pdp8_pkg::word_t w;
        pdp8_pkg::word_t tgt;
        logic [4:0]      page;
        logic            pbit;
        page      = 5'(rand_below(32));
        prog_base = {page, 7'(rand_below(100))};
        prog_hlt  = prog_base + 12'd20;
        load_address(prog_base);
        for (int i = 0; i < 20; i++) begin
            a = prog_base + pdp8_pkg::word_t'(i);
            if (rand_below(4) == 0) begin
                tgt  = a + pdp8_pkg::word_t'(1 + rand_below(int'(prog_hlt - a)));
                pbit = (page != 5'd0) ? 1'b1 : 1'(rand_below(2));
                w    = {3'o5, 1'b0, pbit, tgt[6:0]};
            end else begin
                w = rand_word();
                if (w[11:9] == 3'o5) begin
                    w[11] = 1'b0;
                end
            end
            deposit_word(w);
        end
        deposit_word(12'o7402);
        // word after the HLT, read back by the examine that follows the run
        deposit_word(rand_word());
    endtask

    initial begin
        pdp8_pkg::word_t start;
        pdp8_pkg::word_t a;
        arst_n         = 1'b0;
        sr             = '0;
        sw             = '0;
        halt_sw        = 1'b0;
        single_step_sw = 1'b0;
        model_reset();
        repeat (3) @(posedge clk100);
        arst_n <= 1'b1;

        // state after reset
        @(negedge clk100);
        check_bit("run", run, 1'b0);
        check_state(state, pdp8_pkg::halted);
        check_word("addr", addr, 12'o0000);
        check_word("data", data, 12'o0000);

        // deposit 32 words, read them back
        start = rand_word();
        load_address(start);
        for (int i = 0; i < 32; i++) begin
            deposit_word(rand_word());
        end
        load_address(start);
        for (int i = 0; i < 32; i++) begin
            examine_word();
        end

        // clear keeps pc
        start = rand_word();
        load_address(start);
        deposit_word(rand_word());
        deposit_word(rand_word());
        load_address(start);
        deposit_word(rand_word());
        clear_panel();
        examine_word();

        // free run to HLT
        build_program();
        load_address(prog_base);
        continue_run(1'b0);
        examine_word();

        // single step inside the same program
        @(posedge clk100);
        single_step_sw <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            a = prog_base + pdp8_pkg::word_t'(rand_below(int'(prog_hlt - prog_base)));
            load_address(a);
            continue_run(1'b1);
            examine_word();
        end
        @(posedge clk100);
        single_step_sw <= 1'b0;

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/pdp8_console_top.sv
// console top level, wires panel, sequencer, address unit and memory for the board or testbench
`timescale 1ns/1ns
`default_nettype none

module pdp8_console_top #(
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int ADDR_BITS       = 12
) (
    input  wire              clk100,
    input  wire              arst_n,
    input  pdp8_pkg::word_t  sr,
    input  wire              clear_sw,
    input  wire              addr_load_sw,
    input  wire              dep_sw,
    input  wire              exam_sw,
    input  wire              cont_sw,
    input  wire              halt_sw,
    input  wire              single_step_sw,
    output pdp8_pkg::word_t  addr,
    output pdp8_pkg::word_t  data,
    output logic             run,
    output pdp8_pkg::state_e state
);

    pdp8_pkg::panel_cmd_t cmd;
    pdp8_pkg::mem_ctl_t   ctl;
    pdp8_pkg::word_t      ir;
    pdp8_pkg::word_t      rdata;
    pdp8_pkg::word_t      mem_a;
    logic                 mem_we;

    front_panel #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) front_panel_inst (
        .clk100      (clk100),
        .arst_n      (arst_n),
        .clear_sw    (clear_sw),
        .addr_load_sw(addr_load_sw),
        .dep_sw      (dep_sw),
        .exam_sw     (exam_sw),
        .cont_sw     (cont_sw),
        .cmd         (cmd)
    );

    major_state major_state_inst (
        .clk100        (clk100),
        .arst_n        (arst_n),
        .cmd           (cmd),
        .halt_sw       (halt_sw),
        .single_step_sw(single_step_sw),
        .rdata         (rdata),
        .ctl           (ctl),
        .ir            (ir),
        .run           (run),
        .state         (state)
    );

    // address lamps show ma, data lamps show mb
    mem_addr #(
        .ADDR_BITS(ADDR_BITS)
    ) mem_addr_inst (
        .clk100(clk100),
        .arst_n(arst_n),
        .ctl   (ctl),
        .sr    (sr),
        .ir    (ir),
        .rdata (rdata),
        .addr  (mem_a),
        .ma    (addr),
        .mb    (data),
        .we    (mem_we)
    );

    // deposits write the switch register
    core_mem #(
        .ADDR_BITS(ADDR_BITS)
    ) core_mem_inst (
        .clk100(clk100),
        .addr  (mem_a),
        .wdata (sr),
        .we    (mem_we),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

// File: verilog/core_mem.sv
// word memory standing in for core, written and read synchronously by the address unit
`timescale 1ns/1ns
`default_nettype none

module core_mem #(
    parameter int ADDR_BITS = 12
) (
    input  wire             clk100,
    input  pdp8_pkg::word_t addr,
    input  pdp8_pkg::word_t wdata,
    input  wire             we,
    output pdp8_pkg::word_t rdata
);

    localparam int DEPTH = 1 << ADDR_BITS;

    pdp8_pkg::word_t mem [DEPTH];

    logic [ADDR_BITS-1:0] idx;

    assign idx = addr[ADDR_BITS-1:0];

    // write-first, a deposit shows up on rdata the next cycle
    always_ff @(posedge clk100) begin
        if (we) begin
            mem[idx] <= wdata;
            rdata    <= wdata;
        end else begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_addr.sv
// program counter, memory address and memory buffer registers driven by sequencer pulses
`timescale 1ns/1ns
`default_nettype none

module mem_addr #(
    parameter int ADDR_BITS = 12
) (
    input  wire                clk100,
    input  wire                arst_n,
    input  pdp8_pkg::mem_ctl_t ctl,
    input  pdp8_pkg::word_t    sr,
    input  pdp8_pkg::word_t    ir,
    input  pdp8_pkg::word_t    rdata,
    output pdp8_pkg::word_t    addr,
    output pdp8_pkg::word_t    ma,
    output pdp8_pkg::word_t    mb,
    output logic               we
);

    pdp8_pkg::word_t pc;
    pdp8_pkg::word_t target;
    pdp8_pkg::word_t addr_sel;

    // page bit ir[7], clear means page zero
    assign target = {(ir[7] ? ma[11:7] : 5'b0), ir[6:0]};

    // pc goes out directly whenever a read or write starts this cycle
    assign addr_sel = (ctl.mem_we || ctl.ma_from_pc) ? pc : ma;
    assign addr     = pdp8_pkg::word_t'(addr_sel[ADDR_BITS-1:0]);
    assign we       = ctl.mem_we;

    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            ma <= '0;
            mb <= '0;
        end else begin
            if (ctl.pc_from_sr) begin
                pc <= sr;
            end else if (ctl.pc_jump) begin
                pc <= target;
            end else if (ctl.pc_inc) begin
                pc <= pc + 1'b1;
            end

            if (ctl.pc_from_sr) begin
                ma <= sr;
            end else if (ctl.ma_from_pc) begin
                ma <= pc;
            end

            if (ctl.mb_clear) begin
                mb <= '0;
            end else if (ctl.mb_from_sr) begin
                mb <= sr;
            end else if (ctl.mb_from_mem) begin
                mb <= rdata;
            end
        end
    end

    a_pc_one_src : assert property (@(posedge clk100) disable iff (!arst_n)
        !(ctl.pc_from_sr && ctl.pc_inc));

endmodule

`default_nettype wire

// File: verilog/major_state.sv
// major-state sequencer, runs the console operations and the fetch/execute loop
`timescale 1ns/1ns
`default_nettype none

module major_state (
    input  wire                  clk100,
    input  wire                  arst_n,
    input  pdp8_pkg::panel_cmd_t cmd,
    input  wire                  halt_sw,
    input  wire                  single_step_sw,
    input  pdp8_pkg::word_t      rdata,
    output pdp8_pkg::mem_ctl_t   ctl,
    output pdp8_pkg::word_t      ir,
    output logic                 run,
    output pdp8_pkg::state_e     state
);

    pdp8_pkg::state_e  next_state;
    pdp8_pkg::opcode_e opcode;
    logic              stop;

    assign opcode = pdp8_pkg::opcode_e'(ir[11:9]);
    assign run    = (state == pdp8_pkg::fetch) || (state == pdp8_pkg::fetch_wait) ||
                    (state == pdp8_pkg::execute);

    // HLT or a panel switch ends the run after this instruction
    assign stop = (ir == pdp8_pkg::HLT_WORD) || halt_sw || single_step_sw;

    always_comb begin
        next_state = state;
        if (cmd.clear) begin
            next_state = pdp8_pkg::halted;
        end else begin
            case (state)
                pdp8_pkg::halted: begin
                    if (cmd.addr_load) begin
                        next_state = pdp8_pkg::console_load;
                    end else if (cmd.dep) begin
                        next_state = pdp8_pkg::console_dep;
                    end else if (cmd.exam) begin
                        next_state = pdp8_pkg::console_exam;
                    end else if (cmd.cont) begin
                        next_state = pdp8_pkg::fetch;
                    end
                end
                pdp8_pkg::console_exam: next_state = pdp8_pkg::exam_wait;
                pdp8_pkg::fetch:        next_state = pdp8_pkg::fetch_wait;
                pdp8_pkg::fetch_wait:   next_state = pdp8_pkg::execute;
                pdp8_pkg::execute: begin
                    next_state = stop ? pdp8_pkg::halted : pdp8_pkg::fetch;
                end
                default:                next_state = pdp8_pkg::halted;
            endcase
        end
    end

    // one pulse set per state
    always_comb begin
        ctl          = '0;
        ctl.mb_clear = cmd.clear;
        case (state)
            pdp8_pkg::console_load: ctl.pc_from_sr = 1'b1;
            pdp8_pkg::console_dep: begin
                ctl.mem_we     = 1'b1;
                ctl.mb_from_sr = 1'b1;
                ctl.pc_inc     = 1'b1;
            end
            pdp8_pkg::console_exam: ctl.ma_from_pc = 1'b1;
            pdp8_pkg::exam_wait: begin
                ctl.mb_from_mem = 1'b1;
                ctl.pc_inc      = 1'b1;
            end
            pdp8_pkg::fetch: ctl.ma_from_pc = 1'b1;
            pdp8_pkg::fetch_wait: begin
                ctl.mb_from_mem = 1'b1;
                ctl.pc_inc      = 1'b1;
            end
            pdp8_pkg::execute: ctl.pc_jump = (opcode == pdp8_pkg::op_jmp);
            default: ;
        endcase
    end

    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            state <= pdp8_pkg::halted;
            ir    <= '0;
        end else begin
            state <= next_state;
            if (cmd.clear) begin
                ir <= '0;
            end else if (state == pdp8_pkg::fetch_wait) begin
                ir <= rdata;
            end
        end
    end

    // memory is only written from the panel
    a_no_we_in_run : assert property (@(posedge clk100) disable iff (!arst_n)
        run |-> !ctl.mem_we);

    a_halt_needs_cmd : assert property (@(posedge clk100) disable iff (!arst_n)
        (state == pdp8_pkg::halted && cmd == '0) |=> state == pdp8_pkg::halted);

endmodule

`default_nettype wire

// File: verilog/front_panel.sv
// turns the momentary panel switches into one-cycle command pulses for the sequencer
`timescale 1ns/1ns
`default_nettype none

module front_panel #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  wire                  clk100,
    input  wire                  arst_n,
    input  wire                  clear_sw,
    input  wire                  addr_load_sw,
    input  wire                  dep_sw,
    input  wire                  exam_sw,
    input  wire                  cont_sw,
    output pdp8_pkg::panel_cmd_t cmd
);

    localparam int NSW   = 5;
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [NSW-1:0]   raw;
    logic [NSW-1:0]   sync0;
    logic [NSW-1:0]   sync1;
    logic [NSW-1:0]   level;
    logic [NSW-1:0]   level_q;
    logic [CNT_W-1:0] cnt [NSW];

    // bit order follows the panel_cmd_t fields
    assign raw = {clear_sw, addr_load_sw, dep_sw, exam_sw, cont_sw};

    // two-flop synchronizer
    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            sync0 <= '0;
            sync1 <= '0;
        end else begin
            sync0 <= raw;
            sync1 <= sync0;
        end
    end

    // level follows the input only after it has differed for DEBOUNCE_CYCLES
    always_ff @(posedge clk100 or negedge arst_n) begin
        if (!arst_n) begin
            level   <= '0;
            level_q <= '0;
            for (int i = 0; i < NSW; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            level_q <= level;
            for (int i = 0; i < NSW; i++) begin
                if (sync1[i] == level[i]) begin
                    // bounce back, start over
                    cnt[i] <= '0;
                end else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    level[i] <= sync1[i];
                    cnt[i]   <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // rising edge of the clean level
    assign cmd = pdp8_pkg::panel_cmd_t'(level & ~level_q);

    // the sequencer handles one command at a time
    a_one_cmd : assert property (@(posedge clk100) disable iff (!arst_n)
        $onehot0(cmd));

endmodule

`default_nettype wire

// File: verilog/pdp8_pkg.sv
// shared PDP-8 console types, referenced by scoped name from every design module
`default_nettype none

package pdp8_pkg;

    // one PDP-8 word, data or address
    typedef logic [11:0] word_t;

    // major state of the console sequencer
    typedef enum logic [2:0] {
        halted,
        console_load,
        console_dep,
        console_exam,
        exam_wait,
        fetch,
        fetch_wait,
        execute
    } state_e;

    // ir[11:9] of an instruction
    typedef enum logic [2:0] {
        op_and,
        op_tad,
        op_isz,
        op_dca,
        op_jms,
        op_jmp,
        op_iot,
        op_opr
    } opcode_e;

    // one-cycle pulses from the panel
    typedef struct packed {
        logic clear;
        logic addr_load;
        logic dep;
        logic exam;
        logic cont;
    } panel_cmd_t;

    // sequencer to address unit pulses
    typedef struct packed {
        logic pc_from_sr;
        logic ma_from_pc;
        logic pc_inc;
        logic pc_jump;
        logic mem_we;
        logic mb_from_mem;
        logic mb_from_sr;
        logic mb_clear;
    } mem_ctl_t;

    // group 2 operate HLT
    localparam word_t HLT_WORD = 12'o7402;

endpackage

`default_nettype wire
